// ==== common/pkt_gen_params.svh ====
/* packet generator widths */

`ifndef PKT_GEN_PARAMS_SVH
`define PKT_GEN_PARAMS_SVH

// bytes carried by one stream beat
`define PKT_DATA_BYTES 4

// largest packet the request side can present
`define PKT_MTU_BYTES 64

`define PKT_USER_WIDTH 8

// must hold the value PKT_MTU_BYTES
`define PKT_LEN_WIDTH 7

`define PKT_MAX_BEATS (`PKT_MTU_BYTES / `PKT_DATA_BYTES)

// must hold PKT_MAX_BEATS - 1
`define PKT_BEAT_WIDTH 4

`endif

// ==== common/axis_types_pkg.sv ====
/* stream side types */

`default_nettype none

`include "pkt_gen_params.svh"

package axis_types_pkg;

    // one beat as seen on the AXI-Stream output
    typedef struct packed {
        logic [`PKT_DATA_BYTES*8-1:0] tdata;
        logic [`PKT_DATA_BYTES-1:0]   tkeep;
        logic                         tlast;
        logic [`PKT_USER_WIDTH-1:0]   tuser;
    } axis_beat_t;

endpackage

`default_nettype wire

// ==== common/pkt_ctrl_pkg.sv ====
/* generator control types */

`default_nettype none

`include "pkt_gen_params.svh"

package pkt_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        // all beats handed to the output stage, waiting for the tlast handshake
        LAST_WAIT
    } gen_state_e;

    // request fields kept for the whole packet
    typedef struct packed {
        logic [`PKT_LEN_WIDTH-1:0]  length;
        logic [`PKT_USER_WIDTH-1:0] user;
    } pkt_req_t;

endpackage

`default_nettype wire

// ==== source/pkt_gen_fsm.sv ====
/* packet generator control */

`default_nettype none

`include "pkt_gen_params.svh"

module pkt_gen_fsm (
    input  wire logic                      axis_packet_out,
    input  wire logic                      rst_n,
    input  wire logic                      send_packet_req,
    input  wire logic [`PKT_LEN_WIDTH-1:0] packet_byte_length,
    input  wire logic                      beat_taken,
    input  wire logic                      last_beat,
    input  wire logic                      tlast_done,
    output logic                           busy,
    output logic                           load,
    output logic                           offer
);

    import pkt_ctrl_pkg::*;

    gen_state_e state;
    gen_state_e state_next;

    always_comb begin
        state_next = state;
        load       = 1'b0;
        offer      = 1'b0;
        case (state)
            IDLE: begin
                // zero-length requests are dropped here
                if (send_packet_req && packet_byte_length != '0) begin
                    load       = 1'b1;
                    state_next = SEND;
                end
            end
            SEND: begin
                offer = 1'b1;
                if (beat_taken && last_beat) begin
                    state_next = LAST_WAIT;
                end
            end
            LAST_WAIT: begin
                if (tlast_done) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge axis_packet_out or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign busy = (state != IDLE);

endmodule

`default_nettype wire

// ==== source/beat_counter.sv ====
/* beat counter */

`default_nettype none

`include "pkt_gen_params.svh"

module beat_counter (
    input  wire logic                       axis_packet_out,
    input  wire logic                       rst_n,
    input  wire logic                       clear,
    input  wire logic                       advance,
    input  wire logic [`PKT_LEN_WIDTH-1:0]  length,
    output logic      [`PKT_BEAT_WIDTH-1:0] beat_index,
    output logic                            last_beat
);

    logic [`PKT_LEN_WIDTH-1:0]  len_m1;
    logic [`PKT_BEAT_WIDTH-1:0] last_index;

    // index of the final beat is (length - 1) / bytes per beat, i.e. the
    // length rounded up to whole beats minus one
    assign len_m1     = length - `PKT_LEN_WIDTH'(1);
    assign last_index = `PKT_BEAT_WIDTH'(len_m1 / `PKT_DATA_BYTES);
    assign last_beat  = (beat_index == last_index);

    always_ff @(posedge axis_packet_out or negedge rst_n) begin
        if (!rst_n) begin
            beat_index <= '0;
        end else if (clear) begin
            beat_index <= '0;
        end else if (advance && !last_beat) begin
            beat_index <= beat_index + `PKT_BEAT_WIDTH'(1);
        end
    end

endmodule

`default_nettype wire

// ==== framer/beat_slicer.sv ====
/* packet beat slicer */

`default_nettype none

`include "pkt_gen_params.svh"

module beat_slicer (
    input  wire logic                         axis_packet_out,
    input  wire logic                         rst_n,
    input  wire logic                         load,
    input  wire logic [`PKT_MTU_BYTES*8-1:0]  packet_data,
    input  pkt_ctrl_pkg::pkt_req_t            req,
    input  wire logic [`PKT_BEAT_WIDTH-1:0]   beat_index,
    input  wire logic                         last_beat,
    output axis_types_pkg::axis_beat_t        beat,
    output logic      [`PKT_LEN_WIDTH-1:0]    length
);

    import pkt_ctrl_pkg::*;

    logic [`PKT_MTU_BYTES*8-1:0] data_q;
    pkt_req_t                    req_q;
    logic [`PKT_LEN_WIDTH-1:0]   rem;

    always_ff @(posedge axis_packet_out) begin
        if (load) begin
            data_q <= packet_data;
        end
    end

    always_ff @(posedge axis_packet_out or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= '0;
        end else if (load) begin
            req_q <= req;
        end
    end

    assign length = req_q.length;
    assign rem    = `PKT_LEN_WIDTH'(req_q.length % `PKT_DATA_BYTES);

    always_comb begin
        beat.tdata = data_q[beat_index * (`PKT_DATA_BYTES * 8) +: `PKT_DATA_BYTES * 8];
        beat.tuser = req_q.user;
        beat.tlast = last_beat;
        beat.tkeep = '1;
        // a short final beat keeps only its low remainder bytes
        if (last_beat && rem != '0) begin
            for (int b = 0; b < `PKT_DATA_BYTES; b++) begin
                beat.tkeep[b] = (b < int'(rem));
            end
        end
    end

endmodule

`default_nettype wire

// ==== framer/axis_out_stage.sv ====
/* stream output register */

`default_nettype none

module axis_out_stage (
    input  wire logic                  axis_packet_out,
    input  wire logic                  rst_n,
    input  wire logic                  offer,
    input  axis_types_pkg::axis_beat_t beat_in,
    input  wire logic                  tready,
    output axis_types_pkg::axis_beat_t out_beat,
    output logic                       tvalid,
    output logic                       beat_taken,
    output logic                       tlast_done
);

    import axis_types_pkg::*;

    axis_beat_t beat_q;
    logic       handshake;

    assign handshake = tvalid && tready;

    // the register takes a new beat when empty or when its beat leaves this cycle
    assign beat_taken = offer && (!tvalid || tready);
    assign tlast_done = handshake && beat_q.tlast;

    always_ff @(posedge axis_packet_out) begin
        if (beat_taken) begin
            beat_q <= beat_in;
        end
    end

    always_ff @(posedge axis_packet_out or negedge rst_n) begin
        if (!rst_n) begin
            tvalid <= 1'b0;
        end else if (beat_taken) begin
            tvalid <= 1'b1;
        end else if (handshake) begin
            tvalid <= 1'b0;
        end
    end

    assign out_beat = beat_q;

endmodule

`default_nettype wire

// ==== source/axis_pkt_gen.sv ====
/* AXI-Stream packet generator */

`default_nettype none

`include "pkt_gen_params.svh"

module axis_pkt_gen (
    input  wire logic                         axis_packet_out,
    input  wire logic                         rst_n,
    input  wire logic                         send_packet_req,
    input  wire logic [`PKT_LEN_WIDTH-1:0]    packet_byte_length,
    input  wire logic [`PKT_USER_WIDTH-1:0]   packet_user,
    input  wire logic [`PKT_MTU_BYTES*8-1:0]  packet_data,
    output logic                              busy,
    input  wire logic                         tready,
    output axis_types_pkg::axis_beat_t        out_beat,
    output logic                              tvalid
);

    import axis_types_pkg::*;
    import pkt_ctrl_pkg::*;

    pkt_req_t                   req;
    axis_beat_t                 slice_beat;
    logic                       load;
    logic                       offer;
    logic                       beat_taken;
    logic                       last_beat;
    logic                       tlast_done;
    logic [`PKT_BEAT_WIDTH-1:0] beat_index;
    logic [`PKT_LEN_WIDTH-1:0]  stored_length;

    assign req.length = packet_byte_length;
    assign req.user   = packet_user;

    pkt_gen_fsm fsm0 (
        .axis_packet_out    (axis_packet_out),
        .rst_n              (rst_n),
        .send_packet_req    (send_packet_req),
        .packet_byte_length (packet_byte_length),
        .beat_taken         (beat_taken),
        .last_beat          (last_beat),
        .tlast_done         (tlast_done),
        .busy               (busy),
        .load               (load),
        .offer              (offer)
    );

    // the counter steps each time the output stage takes a beat
    beat_counter counter0 (
        .axis_packet_out (axis_packet_out),
        .rst_n           (rst_n),
        .clear           (load),
        .advance         (beat_taken),
        .length          (stored_length),
        .beat_index      (beat_index),
        .last_beat       (last_beat)
    );

    beat_slicer slicer0 (
        .axis_packet_out (axis_packet_out),
        .rst_n           (rst_n),
        .load            (load),
        .packet_data     (packet_data),
        .req             (req),
        .beat_index      (beat_index),
        .last_beat       (last_beat),
        .beat            (slice_beat),
        .length          (stored_length)
    );

    axis_out_stage out_stage0 (
        .axis_packet_out (axis_packet_out),
        .rst_n           (rst_n),
        .offer           (offer),
        .beat_in         (slice_beat),
        .tready          (tready),
        .out_beat        (out_beat),
        .tvalid          (tvalid),
        .beat_taken      (beat_taken),
        .tlast_done      (tlast_done)
    );

endmodule

`default_nettype wire

// ==== bench/axis_pkt_gen_assert.sv ====
/* stream protocol assertions */

`default_nettype none

module axis_pkt_gen_assert (
    input  wire logic                  axis_packet_out,
    input  wire logic                  rst_n,
    input  wire logic                  busy,
    input  wire logic                  tready,
    input  wire logic                  tvalid,
    input  axis_types_pkg::axis_beat_t out_beat
);

    int fail_count = 0;

    // a stalled beat stays on the bus unchanged until it is taken
    hold_under_stall: assert property (@(posedge axis_packet_out) disable iff (!rst_n)
        (tvalid && !tready) |=> (tvalid && $stable(out_beat)))
    else begin
        $error("out_beat or tvalid changed while the stream was stalled");
        fail_count++;
    end

    valid_needs_busy: assert property (@(posedge axis_packet_out) disable iff (!rst_n)
        tvalid |-> busy)
    else begin
        $error("tvalid was high while the generator was not busy");
        fail_count++;
    end

    quiet_after_reset: assert property (@(posedge axis_packet_out)
        $rose(rst_n) |-> (!tvalid && !busy))
    else begin
        $error("tvalid or busy was high right after reset released");
        fail_count++;
    end

endmodule

bind axis_pkt_gen axis_pkt_gen_assert assert0 (
    .axis_packet_out (axis_packet_out),
    .rst_n           (rst_n),
    .busy            (busy),
    .tready          (tready),
    .tvalid          (tvalid),
    .out_beat        (out_beat)
);

`default_nettype wire

// ==== bench/axis_pkt_gen_checker.sv ====
/* stream beat checker */

`default_nettype none

`include "pkt_gen_params.svh"

module axis_pkt_gen_checker (
    input  wire logic                      axis_packet_out,
    input  wire logic                      rst_n,
    input  wire logic                      send_packet_req,
    input  wire logic [`PKT_LEN_WIDTH-1:0] packet_byte_length,
    input  wire logic                      busy,
    input  wire logic                      tready,
    input  wire logic                      tvalid,
    input  axis_types_pkg::axis_beat_t     out_beat,
    input  wire logic                      strict_timing,
    output int                             mismatch_count,
    output int                             other_count,
    output int                             pending_count
);

    import axis_types_pkg::*;

    axis_beat_t want_q[$];
    int         cycle = 0;
    int         accept_cycle = 0;
    int         beat_num = 0;
    logic       zero_req_seen = 1'b0;

    initial begin
        mismatch_count = 0;
        other_count    = 0;
        pending_count  = 0;
    end

    task automatic expect_beat(input axis_beat_t b);
        want_q.push_back(b);
    endtask

    task automatic compare_field(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
        if (want !== got) begin
            $display("error out_beat.%s: expected 0x%0h, got 0x%0h", name, want, got);
            mismatch_count++;
        end
    endtask

    always @(posedge axis_packet_out) begin
        axis_beat_t want;
        cycle++;
        if (rst_n) begin
            if (zero_req_seen && busy) begin
                $display("a zero-length request made the generator busy");
                other_count++;
            end
            zero_req_seen = send_packet_req && !busy && packet_byte_length == '0;
            if (send_packet_req && !busy && packet_byte_length != '0) begin
                accept_cycle = cycle;
                beat_num     = 0;
            end
            if (tvalid && tready) begin
                if (want_q.size() == 0) begin
                    $display("a beat was sent while no beat was expected");
                    other_count++;
                end else begin
                    want = want_q.pop_front();
                    compare_field("tdata", want.tdata, out_beat.tdata);
                    compare_field("tkeep", 32'(want.tkeep), 32'(out_beat.tkeep));
                    compare_field("tlast", 32'(want.tlast), 32'(out_beat.tlast));
                    compare_field("tuser", 32'(want.tuser), 32'(out_beat.tuser));
                    // with tready held high, beat k completes k + 2 edges after acceptance
                    if (strict_timing && cycle != accept_cycle + beat_num + 2) begin
                        $display("beat %0d of a packet completed at cycle %0d, not at cycle %0d",
                                 beat_num, cycle, accept_cycle + beat_num + 2);
                        other_count++;
                    end
                    beat_num++;
                end
            end
        end
        pending_count = want_q.size();
    end

endmodule

`default_nettype wire

// ==== bench/axis_pkt_gen_tb.sv ====
/* packet generator testbench */

`default_nettype none

`include "pkt_gen_params.svh"

module axis_pkt_gen_tb;

    import axis_types_pkg::*;

    localparam int DIRECTED_BEATS = 20;
    localparam int RANDOM_PKTS    = 8;
    localparam int CYCLE_LIMIT    = (DIRECTED_BEATS + RANDOM_PKTS * `PKT_MAX_BEATS) * 4 + 200;

    logic                         axis_packet_out;
    logic                         rst_n;
    logic                         send_packet_req;
    logic [`PKT_LEN_WIDTH-1:0]    packet_byte_length;
    logic [`PKT_USER_WIDTH-1:0]   packet_user;
    logic [`PKT_MTU_BYTES*8-1:0]  packet_data;
    logic                         busy;
    logic                         tready;
    axis_beat_t                   out_beat;
    logic                         tvalid;
    logic                         strict_timing;
    logic                         random_ready;
    int                           mismatch_count;
    int                           other_count;
    int                           pending_count;
    int                           cycle_count = 0;
    integer                       seed;

    axis_pkt_gen dut0 (
        .axis_packet_out    (axis_packet_out),
        .rst_n              (rst_n),
        .send_packet_req    (send_packet_req),
        .packet_byte_length (packet_byte_length),
        .packet_user        (packet_user),
        .packet_data        (packet_data),
        .busy               (busy),
        .tready             (tready),
        .out_beat           (out_beat),
        .tvalid             (tvalid)
    );

    axis_pkt_gen_checker check0 (
        .axis_packet_out    (axis_packet_out),
        .rst_n              (rst_n),
        .send_packet_req    (send_packet_req),
        .packet_byte_length (packet_byte_length),
        .busy               (busy),
        .tready             (tready),
        .tvalid             (tvalid),
        .out_beat           (out_beat),
        .strict_timing      (strict_timing),
        .mismatch_count     (mismatch_count),
        .other_count        (other_count),
        .pending_count      (pending_count)
    );

    initial begin
        axis_packet_out = 1'b0;
        forever #5 axis_packet_out = ~axis_packet_out;
    end

    always @(posedge axis_packet_out) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles with %0d beats still outstanding",
                     cycle_count, pending_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // roughly one stall in four while back-pressure is on
    always @(negedge axis_packet_out) begin
        if (random_ready) begin
            tready = ($unsigned($random(seed)) % 4) != 0;
        end
    end

    // byte n of the packet sits at data[8n +: 8], so beat i holds bytes 4i .. 4i+3
    function automatic axis_beat_t expected_beat(input int len,
                                                 input logic [`PKT_USER_WIDTH-1:0] user,
                                                 input logic [`PKT_MTU_BYTES*8-1:0] data,
                                                 input int idx);
        axis_beat_t b;
        int         nbeats;
        nbeats  = (len + `PKT_DATA_BYTES - 1) / `PKT_DATA_BYTES;
        b.tdata = data[idx * `PKT_DATA_BYTES * 8 +: `PKT_DATA_BYTES * 8];
        for (int k = 0; k < `PKT_DATA_BYTES; k++) begin
            b.tkeep[k] = (idx * `PKT_DATA_BYTES + k) < len;
        end
        b.tlast = (idx == nbeats - 1);
        b.tuser = user;
        return b;
    endfunction

    task automatic random_data(output logic [`PKT_MTU_BYTES*8-1:0] d);
        for (int w = 0; w < `PKT_MTU_BYTES / 4; w++) begin
            d[w * 32 +: 32] = $random(seed);
        end
    endtask

    task automatic send_packet(input int len, input logic [`PKT_USER_WIDTH-1:0] user,
                               input logic [`PKT_MTU_BYTES*8-1:0] data);
        int nbeats;
        nbeats = (len + `PKT_DATA_BYTES - 1) / `PKT_DATA_BYTES;
        while (busy) begin
            @(negedge axis_packet_out);
        end
        send_packet_req    = 1'b1;
        packet_byte_length = `PKT_LEN_WIDTH'(len);
        packet_user        = user;
        packet_data        = data;
        for (int i = 0; i < nbeats; i++) begin
            check0.expect_beat(expected_beat(len, user, data, i));
        end
        @(negedge axis_packet_out);
        send_packet_req = 1'b0;
    endtask

    // a strobe during a packet must be ignored, so nothing is expected from it
    task automatic strobe_while_busy(input int len);
        while (!busy) begin
            @(negedge axis_packet_out);
        end
        send_packet_req    = 1'b1;
        packet_byte_length = `PKT_LEN_WIDTH'(len);
        packet_user        = 8'hEE;
        @(negedge axis_packet_out);
        send_packet_req = 1'b0;
    endtask

    initial begin
        logic [`PKT_MTU_BYTES*8-1:0] data;
        int                          len;
        int                          total;
        seed               = 80;
        rst_n              = 1'b0;
        send_packet_req    = 1'b0;
        packet_byte_length = '0;
        packet_user        = '0;
        packet_data        = '0;
        tready             = 1'b1;
        strict_timing      = 1'b1;
        random_ready       = 1'b0;
        repeat (3) @(posedge axis_packet_out);
        @(negedge axis_packet_out);
        rst_n = 1'b1;
        @(negedge axis_packet_out);

        random_data(data);
        send_packet(1, 8'hA1, data);
        random_data(data);
        send_packet(4, 8'h5C, data);
        random_data(data);
        send_packet(5, 8'h3E, data);
        random_data(data);
        send_packet(64, 8'hF0, data);
        strobe_while_busy(8);
        send_packet(0, 8'h77, data);

        while (busy) begin
            @(negedge axis_packet_out);
        end
        strict_timing = 1'b0;
        random_ready  = 1'b1;
        for (int i = 0; i < RANDOM_PKTS; i++) begin
            random_data(data);
            len = 1 + int'($unsigned($random(seed)) % `PKT_MTU_BYTES);
            send_packet(len, 8'h10 + 8'(i * 23), data);
            if (i % 2 == 1) begin
                strobe_while_busy(len);
            end
        end
        while (busy || tvalid) begin
            @(negedge axis_packet_out);
        end
        repeat (2) @(negedge axis_packet_out);

        total = mismatch_count + other_count + dut0.assert0.fail_count + pending_count;
        $display("%0d mismatches, %0d other errors, %0d assertion failures, %0d beats left",
                 mismatch_count, other_count, dut0.assert0.fail_count, pending_count);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+common
common/axis_types_pkg.sv
common/pkt_ctrl_pkg.sv
source/pkt_gen_fsm.sv
source/beat_counter.sv
framer/beat_slicer.sv
framer/axis_out_stage.sv
source/axis_pkt_gen.sv
bench/axis_pkt_gen_assert.sv
bench/axis_pkt_gen_checker.sv
bench/axis_pkt_gen_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the packet generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module axis_pkt_gen_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vaxis_pkt_gen_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
